// File: files.f
+incdir+include
design/lsu_pkg.sv
design/lsu_addr_decode.sv
design/lsu_dccm_port.sv
design/lsu_dc3_stage.sv
design/lsu_dccm_ctl.sv
testbench/tb_dccm_model.sv
testbench/tb_lsu_dccm_ctl.sv

// File: Makefile
# Verilator build and run for the LSU DCCM data path testbench

VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing
TOP        ?= tb_lsu_dccm_ctl
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/tb_lsu_dccm_ctl.sv
// Testbench for the LSU DCCM data path. Random packets and store buffer words
// from an LFSR are checked against a shadow memory and a reference function.

`timescale 1ns/1ns
`include "lsu_config.svh"

module tb_lsu_dccm_ctl
   import lsu_pkg::*;
;

   localparam int          NUM_CYCLES = 400;
   localparam int          TIMEOUT    = 50;
   localparam logic [31:0] DCCM_BASE  = `LSU_DCCM_BASE;
   localparam logic [31:0] PIC_BASE   = `LSU_PIC_BASE;

   typedef struct packed {
      logic          load;     // load_valid due in dc3
      logic          pic_wr;   // picm_wren due in dc3
      logic [31:0]   data;
      logic [31:0]   addr;
   } exp_t;

   logic          clk;
   logic          arst_n;
   lsu_pkt_t      pkt;
   stbuf_req_t    req;
   logic          stbuf_commit, dccm_rden, dccm_wren, picm_rden, picm_wren, load_valid;
   logic [15:0]   dccm_rd_addr_lo, dccm_rd_addr_hi, dccm_wr_addr;
   logic [31:0]   dccm_rd_data_lo, dccm_rd_data_hi, dccm_wr_data, load_data;
   logic [31:0]   picm_rdaddr, picm_rd_data, picm_wraddr, picm_wr_data;

   logic [15:0]   lfsr_state;
   logic [31:0]   shadow_mem [1 << 14];
   logic [31:0]   shadow_pic [1 << 13];
   exp_t          exp_q [$];
   logic          checking;
   logic          req_done;
   int            errors, timeouts, commits, held, busy_commits;

   lsu_dccm_ctl UUT (.*, .lsu_pkt(pkt), .stbuf_req(req));
   tb_dccm_model u_model (.*);

   initial clk = 1'b0;
   always #50 clk = ~clk;

   // --------------------
   // helpers
   // --------------------
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0]   v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = {lfsr_state[14:0],
                       lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         errors++;
         $display("error %s expected %b actual %b", name, exp, act);
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         errors++;
         $display("error %s expected %h actual %h", name, exp, act);
      end
   endtask

   function automatic lsu_region_e region_of(input logic [31:0] addr);
      if (addr[31:16] == DCCM_BASE[31:16]) return LSU_REGION_DCCM;
      if (addr[31:15] == PIC_BASE[31:15]) return LSU_REGION_PIC;
      return LSU_REGION_NONE;
   endfunction

   function automatic logic [15:0] end_addr(input lsu_pkt_t p);
      case (p.size)
         LSU_SIZE_HALF: return p.addr[15:0] + 16'd1;
         LSU_SIZE_WORD: return p.addr[15:0] + 16'd3;
         default:       return p.addr[15:0];
      endcase
   endfunction

   // reference load result as {end word, start word} shifted by the byte offset
   function automatic logic [31:0] expected_load(input lsu_pkt_t p);
      logic [15:0]   hi_a;
      logic [63:0]   pair;
      if (region_of(p.addr) == LSU_REGION_PIC) return shadow_pic[p.addr[14:2]];
      hi_a = end_addr(p);
      pair = {shadow_mem[hi_a[15:2]], shadow_mem[p.addr[15:2]]} >> {p.addr[1:0], 3'b000};
      return pair[31:0];
   endfunction

   // --------------------
   // compare process
   // --------------------
   always @(posedge clk) begin
      exp_t          rec;
      exp_t          got;
      logic          pic_upd;
      logic          is_ld;
      logic          exp_rden;
      logic          exp_commit;
      logic [15:0]   hi_a;
      lsu_region_e   reg_v;
      if (checking) begin
         pic_upd = 1'b0;
         if (exp_q.size() == 2) begin   // packet from two cycles back is in dc3
            got = exp_q.pop_front();
            check_bit("dc3 load_valid", got.load, load_valid);
            if (got.load) check_word("dc3 load_data", got.data, load_data);
            check_bit("dc3 picm_wren", got.pic_wr, picm_wren);
            if (got.pic_wr) begin
               check_word("dc3 picm_wraddr", got.addr, picm_wraddr);
               check_word("dc3 picm_wr_data", got.data, picm_wr_data);
               pic_upd = 1'b1;
            end
         end
         reg_v    = region_of(pkt.addr);
         is_ld    = pkt.valid && (pkt.op == LSU_OP_LOAD);
         exp_rden = is_ld && (reg_v == LSU_REGION_DCCM);
         hi_a     = end_addr(pkt);
         check_bit("dc1 dccm_rden", exp_rden, dccm_rden);
         if (exp_rden) begin
            check_word("dc1 rd_addr_lo", {16'b0, pkt.addr[15:0]}, {16'b0, dccm_rd_addr_lo});
            check_word("dc1 rd_addr_hi", {16'b0, hi_a}, {16'b0, dccm_rd_addr_hi});
         end
         check_bit("dc1 picm_rden", is_ld && (reg_v == LSU_REGION_PIC), picm_rden);
         if (is_ld && (reg_v == LSU_REGION_PIC)) begin
            check_word("dc1 picm_rdaddr", PIC_BASE | {17'b0, pkt.addr[14:0]}, picm_rdaddr);
         end
         rec.load   = is_ld && (reg_v != LSU_REGION_NONE);
         rec.pic_wr = pkt.valid && (pkt.op == LSU_OP_STORE) && (reg_v == LSU_REGION_PIC);
         rec.addr   = PIC_BASE | {17'b0, pkt.addr[14:0]};
         rec.data   = rec.load ? expected_load(pkt) : pkt.data;
         exp_q.push_back(rec);
         // store buffer arbitration against the dc1 read banks
         exp_commit = req.valid && (!exp_rden || ((req.addr[2] != pkt.addr[2]) &&
                                                  (req.addr[2] != hi_a[2])));
         check_bit("stbuf_commit", exp_commit, stbuf_commit);
         check_bit("dccm_wren", exp_commit, dccm_wren);
         if (stbuf_commit) begin
            check_word("dccm_wr_addr", {16'b0, req.addr}, {16'b0, dccm_wr_addr});
            check_word("dccm_wr_data", req.data, dccm_wr_data);
            shadow_mem[req.addr[15:2]] = req.data;
            req_done = 1'b1;
            commits++;
            if (exp_rden) busy_commits++;
         end else if (req.valid) begin
            held++;
         end
         if (pic_upd) shadow_pic[got.addr[14:2]] = got.data;
      end
   end

   // --------------------
   // stimulus
   // --------------------
   task automatic update_stbuf(input logic allow_new);
      logic [31:0]   r;
      if (req_done) begin
         req.valid = 1'b0;
         req_done  = 1'b0;
      end
      if (!req.valid && allow_new) begin
         r = take_bits(2);
         if (r[1:0] != 2'd0) begin
            r = take_bits(4);
            req.addr  = {10'b0, r[3:0], 2'b00};
            r = take_bits(32);
            req.data  = r;
            req.valid = 1'b1;
         end
      end
   endtask

   task automatic drive_packet();
      logic [31:0]   k;
      logic [31:0]   r;
      k = take_bits(3);
      pkt = '0;
      if (k < 4) begin   // DCCM load that may cross a word
         r = take_bits(6);
         pkt.addr = DCCM_BASE | {26'b0, r[5:0]};
         r = take_bits(2);
         pkt.size = (r[1:0] == 2'd3) ? LSU_SIZE_WORD : lsu_size_e'(r[1:0]);
         pkt.op   = LSU_OP_LOAD;
         pkt.valid = 1'b1;
      end else if (k < 6) begin   // PIC load or store
         r = take_bits(4);
         pkt.addr  = PIC_BASE | {26'b0, r[3:0], 2'b00};
         pkt.op    = (k == 5) ? LSU_OP_STORE : LSU_OP_LOAD;
         pkt.size  = LSU_SIZE_WORD;
         r = take_bits(32);
         pkt.data  = r;
         pkt.valid = 1'b1;
      end else if (k == 6) begin   // outside both regions
         r = take_bits(9);
         pkt.addr  = 32'h8000_0000 | {24'b0, r[7:0]};
         pkt.op    = lsu_op_e'(r[8]);
         pkt.valid = 1'b1;
      end
   endtask

   initial begin
      int wait_cnt;
      lfsr_state = 16'd22;
      errors = 0;
      timeouts = 0;
      commits = 0;
      held = 0;
      busy_commits = 0;
      pkt = '0;
      req = '0;
      arst_n = 1'b0;
      checking = 1'b0;
      req_done = 1'b0;
      for (int i = 0; i < 4; i++) @(negedge clk);
      arst_n = 1'b1;
      check_bit("reset load_valid", 1'b0, load_valid);
      check_bit("reset dccm_wren", 1'b0, dccm_wren);
      check_bit("reset dccm_rden", 1'b0, dccm_rden);
      check_bit("reset picm_rden", 1'b0, picm_rden);
      check_bit("reset picm_wren", 1'b0, picm_wren);
      check_bit("reset stbuf_commit", 1'b0, stbuf_commit);
      // shadow copy starts from the preloaded model contents
      for (int j = 0; j < (1 << 13); j++) begin
         shadow_mem[2 * j]     = u_model.bank0[j];
         shadow_mem[2 * j + 1] = u_model.bank1[j];
         shadow_pic[j]         = u_model.pic_regs[j];
      end
      checking = 1'b1;
      for (int i = 0; i < NUM_CYCLES; i++) begin
         @(negedge clk);
         update_stbuf(1'b1);
         drive_packet();
      end
      // drain the store buffer with the load side idle
      @(negedge clk);
      pkt = '0;
      update_stbuf(1'b0);
      wait_cnt = 0;
      while (req.valid && wait_cnt < TIMEOUT) begin
         @(negedge clk);
         update_stbuf(1'b0);
         wait_cnt++;
      end
      if (req.valid) begin
         timeouts++;
         $display("timeout while waiting for the store buffer request to commit");
      end
      for (int i = 0; i < 3; i++) @(negedge clk);   // flush dc2 and dc3
      checking = 1'b0;
      if (commits == 0 || held == 0 || busy_commits == 0) begin
         errors++;
         $display("store buffer arbitration was not fully exercised, %0d commits, %0d beside a read, %0d held cycles",
                  commits, busy_commits, held);
      end
      $display("errors %0d, timeouts %0d, commits %0d, held cycles %0d",
               errors, timeouts, commits, held);
      if (errors == 0 && timeouts == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: testbench/tb_dccm_model.sv
// Behavioral two-bank DCCM and PIC register file for the LSU testbench.
// Reads return one cycle after the read enable, writes land at the clock edge.

`timescale 1ns/1ns
`include "lsu_config.svh"

module tb_dccm_model
   import lsu_pkg::*;
(
   input  logic                        clk,
   input  logic                        dccm_rden,
   input  logic [`LSU_DCCM_BITS-1:0]   dccm_rd_addr_lo,
   input  logic [`LSU_DCCM_BITS-1:0]   dccm_rd_addr_hi,
   output logic [`LSU_DATA_WIDTH-1:0]  dccm_rd_data_lo,
   output logic [`LSU_DATA_WIDTH-1:0]  dccm_rd_data_hi,
   input  logic                        dccm_wren,
   input  logic [`LSU_DCCM_BITS-1:0]   dccm_wr_addr,
   input  logic [`LSU_DATA_WIDTH-1:0]  dccm_wr_data,
   input  logic                        picm_rden,
   input  logic [31:0]                 picm_rdaddr,
   output logic [31:0]                 picm_rd_data,
   input  logic                        picm_wren,
   input  logic [31:0]                 picm_wraddr,
   input  logic [31:0]                 picm_wr_data
);

   localparam int DB        = `LSU_DCCM_BITS;
   localparam int PB        = `LSU_PIC_BITS;
   localparam int BANK_SIZE = 1 << (DB - 3);   // words per bank
   localparam int PIC_REGS  = 1 << (PB - 2);

   logic [31:0]   bank0 [BANK_SIZE];   // even words
   logic [31:0]   bank1 [BANK_SIZE];   // odd words
   logic [31:0]   pic_regs [PIC_REGS];

   function automatic logic [31:0] bank_read(input logic [DB-1:0] addr);
      if (addr[`LSU_BANK_LSB]) begin
         return bank1[addr[DB-1:3]];
      end
      return bank0[addr[DB-1:3]];
   endfunction

   // initial content depends on the whole word address
   initial begin
      for (int j = 0; j < BANK_SIZE; j++) begin
         bank0[j] = (32'(j) * 2 + 0) * 32'h9E37_79B1 ^ 32'h5A5A_0000;
         bank1[j] = (32'(j) * 2 + 1) * 32'h9E37_79B1 ^ 32'h5A5A_0000;
      end
      for (int j = 0; j < PIC_REGS; j++) begin
         pic_regs[j] = 32'(j) * 32'h0100_0193 ^ 32'hC0DE_0000;
      end
      dccm_rd_data_lo = '0;
      dccm_rd_data_hi = '0;
      picm_rd_data    = '0;
   end

   always @(posedge clk) begin
      if (dccm_rden) begin
         dccm_rd_data_lo <= bank_read(dccm_rd_addr_lo);
         dccm_rd_data_hi <= bank_read(dccm_rd_addr_hi);
      end
      if (dccm_wren) begin
         if (dccm_wr_addr[`LSU_BANK_LSB]) begin
            bank1[dccm_wr_addr[DB-1:3]] <= dccm_wr_data;
         end else begin
            bank0[dccm_wr_addr[DB-1:3]] <= dccm_wr_data;
         end
      end
      if (picm_rden) begin
         picm_rd_data <= pic_regs[picm_rdaddr[PB-1:2]];
      end
      if (picm_wren) begin
         pic_regs[picm_wraddr[PB-1:2]] <= picm_wr_data;
      end
   end

endmodule

// File: design/lsu_dccm_ctl.sv
// Top level of the LSU DCCM data path: dc1 decode, write port arbitration
// and the dc2/dc3 stages, wired to the DCCM and PIC ports.

`timescale 1ns/1ns
`include "lsu_config.svh"

module lsu_dccm_ctl
   import lsu_pkg::*;
(
   input  logic                        clk,
   input  logic                        arst_n,

   input  lsu_pkt_t                    lsu_pkt,     // one packet per cycle
   input  stbuf_req_t                  stbuf_req,   // held until stbuf_commit
   output logic                        stbuf_commit,

   // DCCM port
   output logic                        dccm_rden,
   output logic [`LSU_DCCM_BITS-1:0]   dccm_rd_addr_lo,
   output logic [`LSU_DCCM_BITS-1:0]   dccm_rd_addr_hi,
   input  logic [`LSU_DATA_WIDTH-1:0]  dccm_rd_data_lo,   // cycle after dccm_rden
   input  logic [`LSU_DATA_WIDTH-1:0]  dccm_rd_data_hi,
   output logic                        dccm_wren,
   output logic [`LSU_DCCM_BITS-1:0]   dccm_wr_addr,
   output logic [`LSU_DATA_WIDTH-1:0]  dccm_wr_data,

   // PIC port
   output logic                        picm_rden,
   output logic [31:0]                 picm_rdaddr,
   input  logic [31:0]                 picm_rd_data,      // cycle after picm_rden
   output logic                        picm_wren,
   output logic [31:0]                 picm_wraddr,
   output logic [31:0]                 picm_wr_data,

   // load return, dc3
   output logic                        load_valid,
   output logic [`LSU_DATA_WIDTH-1:0]  load_data
);

   lsu_stage_t  stage_dc1;

   lsu_addr_decode u_addr_decode (
      .lsu_pkt     (lsu_pkt),
      .stage_dc1   (stage_dc1),
      .dc1_rden    (dccm_rden),
      .rd_addr_lo  (dccm_rd_addr_lo),
      .rd_addr_hi  (dccm_rd_addr_hi),
      .picm_rden   (picm_rden),
      .picm_rdaddr (picm_rdaddr)
   );

   lsu_dccm_port u_dccm_port (
      .dc1_rden     (dccm_rden),
      .rd_addr_lo   (dccm_rd_addr_lo),
      .rd_addr_hi   (dccm_rd_addr_hi),
      .stbuf_req    (stbuf_req),
      .stbuf_commit (stbuf_commit),
      .dccm_wren    (dccm_wren),
      .dccm_wr_addr (dccm_wr_addr),
      .dccm_wr_data (dccm_wr_data)
   );

   lsu_dc3_stage u_dc3_stage (
      .clk             (clk),
      .arst_n          (arst_n),
      .stage_dc1       (stage_dc1),
      .dccm_rd_data_lo (dccm_rd_data_lo),
      .dccm_rd_data_hi (dccm_rd_data_hi),
      .picm_rd_data    (picm_rd_data),
      .load_valid      (load_valid),
      .load_data       (load_data),
      .picm_wren       (picm_wren),
      .picm_wraddr     (picm_wraddr),
      .picm_wr_data    (picm_wr_data)
   );

endmodule

// File: design/lsu_dc3_stage.sv
// dc2 and dc3 pipeline registers with load alignment and PIC access.
// Loads return in dc3, two cycles after dc1. PIC stores write in dc3.

`timescale 1ns/1ns
`include "lsu_config.svh"

module lsu_dc3_stage
   import lsu_pkg::*;
(
   input  logic                        clk,
   input  logic                        arst_n,
   input  lsu_stage_t                  stage_dc1,
   input  logic [`LSU_DATA_WIDTH-1:0]  dccm_rd_data_lo,
   input  logic [`LSU_DATA_WIDTH-1:0]  dccm_rd_data_hi,
   input  logic [31:0]                 picm_rd_data,
   output logic                        load_valid,
   output logic [`LSU_DATA_WIDTH-1:0]  load_data,
   output logic                        picm_wren,
   output logic [31:0]                 picm_wraddr,
   output logic [31:0]                 picm_wr_data
);

   localparam int          DW       = `LSU_DATA_WIDTH;
   localparam int          PB       = `LSU_PIC_BITS;
   localparam logic [31:0] PIC_BASE = `LSU_PIC_BASE;

   lsu_stage_t             stage_dc2;
   lsu_stage_t             stage_dc3;
   logic                   dccm_load_dc2;
   logic                   pic_load_dc2;
   logic [DW-1:0]          dccm_lo_dc3;
   logic [DW-1:0]          dccm_hi_dc3;
   logic [31:0]            pic_data_dc3;
   logic [2*DW-1:0]        dccm_pair_dc3;
   logic [DW-1:0]          dccm_load_dc3;
   logic                   load_dc3;

   // --------------------
   // stage registers
   // --------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         stage_dc2 <= '0;
         stage_dc3 <= '0;
      end else begin
         stage_dc2 <= stage_dc1;
         stage_dc3 <= stage_dc2;
      end
   end

   // --------------------
   // dc2 data capture
   // --------------------
   assign dccm_load_dc2 = stage_dc2.valid & (stage_dc2.op == LSU_OP_LOAD) &
                          (stage_dc2.region == LSU_REGION_DCCM);
   assign pic_load_dc2  = stage_dc2.valid & (stage_dc2.op == LSU_OP_LOAD) &
                          (stage_dc2.region == LSU_REGION_PIC);

   always_ff @(posedge clk) begin
      if (dccm_load_dc2) begin
         dccm_lo_dc3 <= dccm_rd_data_lo;   // start word
         dccm_hi_dc3 <= dccm_rd_data_hi;   // end word
      end
      if (pic_load_dc2) begin
         pic_data_dc3 <= picm_rd_data;
      end
   end

   // --------------------
   // dc3 load return
   // --------------------
   // right justified, no sign or size masking
   assign dccm_pair_dc3 = {dccm_hi_dc3, dccm_lo_dc3};
   assign dccm_load_dc3 = DW'(dccm_pair_dc3 >> {stage_dc3.addr_lo, 3'b000});

   assign load_dc3   = stage_dc3.valid & (stage_dc3.op == LSU_OP_LOAD);
   assign load_valid = load_dc3 & ((stage_dc3.region == LSU_REGION_DCCM) |
                                   (stage_dc3.region == LSU_REGION_PIC));
   assign load_data  = (stage_dc3.region == LSU_REGION_PIC) ? pic_data_dc3 : dccm_load_dc3;

   // --------------------
   // PIC store, dc3 acts as commit
   // --------------------
   assign picm_wren    = stage_dc3.valid & (stage_dc3.op == LSU_OP_STORE) &
                         (stage_dc3.region == LSU_REGION_PIC);
   assign picm_wraddr  = PIC_BASE | {{(32-PB){1'b0}}, stage_dc3.pic_offset};
   assign picm_wr_data = stage_dc3.data;

   // one dc3 slot, so a load return and a PIC write cannot coexist
   a_wren_vs_load : assert property (@(posedge clk) disable iff (!arst_n)
                                     !(picm_wren && load_valid))
      else $error("picm_wren and load_valid high in the same cycle");

endmodule

// File: design/lsu_dccm_port.sv
// Store buffer commit arbitration against the dc1 load read.
// The store buffer word takes the write port unless it collides with a read bank.

`timescale 1ns/1ns
`include "lsu_config.svh"

module lsu_dccm_port
   import lsu_pkg::*;
(
   input  logic                        dc1_rden,
   input  logic [`LSU_DCCM_BITS-1:0]   rd_addr_lo,
   input  logic [`LSU_DCCM_BITS-1:0]   rd_addr_hi,
   input  stbuf_req_t                  stbuf_req,
   output logic                        stbuf_commit,
   output logic                        dccm_wren,
   output logic [`LSU_DCCM_BITS-1:0]   dccm_wr_addr,
   output logic [`LSU_DATA_WIDTH-1:0]  dccm_wr_data
);

   localparam int BANK = `LSU_BANK_LSB;

   logic          bank_hit_lo;
   logic          bank_hit_hi;

   // --------------------
   // bank conflict
   // --------------------
   assign bank_hit_lo = stbuf_req.addr[BANK] == rd_addr_lo[BANK];
   assign bank_hit_hi = stbuf_req.addr[BANK] == rd_addr_hi[BANK];   // unaligned end word

   // a crossing load uses both banks, so any pending request waits then
   assign stbuf_commit = stbuf_req.valid & (~dc1_rden | ~(bank_hit_lo | bank_hit_hi));

   // --------------------
   // write port
   // --------------------
   assign dccm_wren    = stbuf_commit;
   assign dccm_wr_addr = stbuf_req.addr;
   assign dccm_wr_data = stbuf_req.data;

   // checked against the port outputs that leave for the memory
   always_comb begin
      if (dccm_wren) begin
         a_wren_has_req : assert (stbuf_req.valid)
            else $error("dccm write without a store buffer request");
      end
      if (dccm_wren && dc1_rden) begin
         a_no_bank_clash : assert ((dccm_wr_addr[BANK] != rd_addr_lo[BANK]) &&
                                   (dccm_wr_addr[BANK] != rd_addr_hi[BANK]))
            else $error("dccm write shares a bank with the dc1 read");
      end
   end

endmodule

// File: design/lsu_addr_decode.sv
// dc1 decode of an LSU packet: region select, end address and read requests.
// Purely combinational, drives the DCCM read port and the PIC read port.

`timescale 1ns/1ns
`include "lsu_config.svh"

module lsu_addr_decode
   import lsu_pkg::*;
(
   input  lsu_pkt_t                   lsu_pkt,
   output lsu_stage_t                 stage_dc1,
   output logic                       dc1_rden,
   output logic [`LSU_DCCM_BITS-1:0]  rd_addr_lo,
   output logic [`LSU_DCCM_BITS-1:0]  rd_addr_hi,
   output logic                       picm_rden,
   output logic [31:0]                picm_rdaddr
);

   localparam int          DB        = `LSU_DCCM_BITS;
   localparam int          PB        = `LSU_PIC_BITS;
   localparam logic [31:0] DCCM_BASE = `LSU_DCCM_BASE;
   localparam logic [31:0] PIC_BASE  = `LSU_PIC_BASE;

   lsu_region_e            region;
   logic [1:0]             size_span;   // bytes past the start byte
   logic                   is_load;

   // --------------------
   // region decode
   // --------------------
   always_comb begin
      if (lsu_pkt.addr[31:DB] == DCCM_BASE[31:DB]) begin
         region = LSU_REGION_DCCM;
      end else if (lsu_pkt.addr[31:PB] == PIC_BASE[31:PB]) begin
         region = LSU_REGION_PIC;
      end else begin
         region = LSU_REGION_NONE;
      end
   end

   // --------------------
   // start and end address
   // --------------------
   always_comb begin
      case (lsu_pkt.size)
         LSU_SIZE_HALF: size_span = 2'd1;
         LSU_SIZE_WORD: size_span = 2'd3;
         default:       size_span = 2'd0;   // byte
      endcase
   end

   assign rd_addr_lo = lsu_pkt.addr[DB-1:0];
   assign rd_addr_hi = lsu_pkt.addr[DB-1:0] + {{(DB-2){1'b0}}, size_span};   // may cross a word

   assign is_load  = lsu_pkt.valid & (lsu_pkt.op == LSU_OP_LOAD);
   assign dc1_rden = is_load & (region == LSU_REGION_DCCM);

   // PIC registers are 32 bits wide, the base has no bits under the offset
   assign picm_rden   = is_load & (region == LSU_REGION_PIC);
   assign picm_rdaddr = PIC_BASE | {{(32-PB){1'b0}}, lsu_pkt.addr[PB-1:0]};

   assign stage_dc1 = '{
      valid:      lsu_pkt.valid,
      op:         lsu_pkt.op,
      region:     region,
      addr_lo:    lsu_pkt.addr[1:0],
      pic_offset: lsu_pkt.addr[PB-1:0],
      data:       lsu_pkt.data
   };

endmodule

// File: design/lsu_pkg.sv
// Types shared by the LSU DCCM pipeline and its testbench.
// Pull them in with a wildcard import in the module header.

`include "lsu_config.svh"

package lsu_pkg;

   typedef enum logic {
      LSU_OP_LOAD  = 1'b0,
      LSU_OP_STORE = 1'b1
   } lsu_op_e;

   typedef enum logic [1:0] {
      LSU_SIZE_BYTE = 2'd0,
      LSU_SIZE_HALF = 2'd1,
      LSU_SIZE_WORD = 2'd2
   } lsu_size_e;

   typedef enum logic [1:0] {
      LSU_REGION_NONE = 2'd0,
      LSU_REGION_DCCM = 2'd1,
      LSU_REGION_PIC  = 2'd2
   } lsu_region_e;

   // packet from the issue side, 68 bits
   typedef struct packed {
      logic                       valid;
      lsu_op_e                    op;
      lsu_size_e                  size;
      logic [31:0]                addr;
      logic [31:0]                data;   // store data, unused for loads
   } lsu_pkt_t;

   // one store buffer word waiting for the write port, 49 bits
   typedef struct packed {
      logic                       valid;
      logic [`LSU_DCCM_BITS-1:0]  addr;   // word aligned
      logic [31:0]                data;
   } stbuf_req_t;

   // per-stage record carried from dc1 to dc3
   typedef struct packed {
      logic                       valid;
      lsu_op_e                    op;
      lsu_region_e                region;
      logic [1:0]                 addr_lo;      // byte offset for the load shift
      logic [`LSU_PIC_BITS-1:0]   pic_offset;
      logic [31:0]                data;
   } lsu_stage_t;

endpackage

// File: include/lsu_config.svh
// Address map and width macros for the LSU DCCM data path.
// Included by the package and by every RTL file that sizes a port from them.

`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// --------------------
// address map
// --------------------
`define LSU_DCCM_BASE   32'hF004_0000  // DCCM region base, aligned to the DCCM size
`define LSU_DCCM_BITS   16             // DCCM byte address width, 64 KB
`define LSU_PIC_BASE    32'hF00C_0000  // PIC register block base
`define LSU_PIC_BITS    15             // PIC offset width

// --------------------
// data path
// --------------------
`define LSU_BANK_LSB    2              // bank select, even/odd words
`define LSU_DATA_WIDTH  32             // one DCCM word

`endif
